// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int XLEN       = 32;
    localparam int OP_W       = 6;
    localparam int ALU_OP_W   = 12;

    // one-hot alu operation bits
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [OP_W-1:0] OP_SPECIAL = 6'h00;
    localparam logic [OP_W-1:0] OP_J       = 6'h02;
    localparam logic [OP_W-1:0] OP_JAL     = 6'h03;
    localparam logic [OP_W-1:0] OP_BEQ     = 6'h04;
    localparam logic [OP_W-1:0] OP_BNE     = 6'h05;
    localparam logic [OP_W-1:0] OP_ADDIU   = 6'h09;
    localparam logic [OP_W-1:0] OP_SLTI    = 6'h0a;
    localparam logic [OP_W-1:0] OP_SLTIU   = 6'h0b;
    localparam logic [OP_W-1:0] OP_ANDI    = 6'h0c;
    localparam logic [OP_W-1:0] OP_ORI     = 6'h0d;
    localparam logic [OP_W-1:0] OP_XORI    = 6'h0e;
    localparam logic [OP_W-1:0] OP_LUI     = 6'h0f;
    localparam logic [OP_W-1:0] OP_LW      = 6'h23;
    localparam logic [OP_W-1:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [OP_W-1:0] FN_SLL  = 6'h00;
    localparam logic [OP_W-1:0] FN_SRL  = 6'h02;
    localparam logic [OP_W-1:0] FN_SRA  = 6'h03;
    localparam logic [OP_W-1:0] FN_JR   = 6'h08;
    localparam logic [OP_W-1:0] FN_ADDU = 6'h21;
    localparam logic [OP_W-1:0] FN_SUBU = 6'h23;
    localparam logic [OP_W-1:0] FN_AND  = 6'h24;
    localparam logic [OP_W-1:0] FN_OR   = 6'h25;
    localparam logic [OP_W-1:0] FN_XOR  = 6'h26;
    localparam logic [OP_W-1:0] FN_NOR  = 6'h27;
    localparam logic [OP_W-1:0] FN_SLT  = 6'h2a;
    localparam logic [OP_W-1:0] FN_SLTU = 6'h2b;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef struct packed {
        logic [OP_W-1:0]       op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            sa;
        logic [OP_W-1:0]       func;
    } r_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]       op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0] op;
        logic [25:0]     index26;
    } j_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        j_fmt_t j_view;
    } inst_t;

endpackage

`default_nettype wire

// File: id_stage_reg.sv
`default_nettype none

module id_stage_reg
    import mips_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            flush,
    input  wire            fs_valid,
    input  wire inst_t     fs_inst,
    input  wire [XLEN-1:0] fs_pc,
    input  wire            es_allowin,
    input  wire            ready_go,
    output logic           ds_valid,
    output inst_t          ds_inst,
    output logic [XLEN-1:0] ds_pc,
    output logic           ds_allowin,
    output logic           ds_to_es_valid
);

    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`default_nettype none

module inst_decoder
    import mips_pkg::*;
(
    input  wire inst_t                ds_inst,
    output logic [ALU_OP_W-1:0]       alu_op,
    output logic                      src1_is_sa,
    output logic                      src1_is_pc,
    output logic                      src2_is_simm,
    output logic                      src2_is_zimm,
    output logic                      src2_is_8,
    output logic                      res_from_mem,
    output logic                      gr_we,
    output logic                      mem_we,
    output logic [REG_ADDR_W-1:0]     dest,
    output logic [15:0]               imm,
    output logic                      is_beq,
    output logic                      is_bne,
    output logic                      is_j,
    output logic                      is_jal,
    output logic                      is_jr,
    output logic                      ex_ri
);

    logic [OP_W-1:0] op;
    logic [OP_W-1:0] func;
    logic            special;
    logic            rs_zero;
    logic            sa_zero;
    logic            alu_r;
    logic            inst_addu, inst_subu, inst_slt, inst_sltu;
    logic            inst_and, inst_or, inst_xor, inst_nor;
    logic            inst_sll, inst_srl, inst_sra;
    logic            inst_addiu, inst_slti, inst_sltiu;
    logic            inst_andi, inst_ori, inst_xori, inst_lui;
    logic            inst_lw, inst_sw;
    logic            dst_is_rt;

    assign op      = ds_inst.r_view.op;
    assign func    = ds_inst.r_view.func;
    assign special = (op == OP_SPECIAL);
    assign rs_zero = (ds_inst.r_view.rs == '0);
    assign sa_zero = (ds_inst.r_view.sa == '0);

    // three-register ops need a zero shift field
    assign alu_r     = special && sa_zero;
    assign inst_addu = alu_r && func == FN_ADDU;
    assign inst_subu = alu_r && func == FN_SUBU;
    assign inst_slt  = alu_r && func == FN_SLT;
    assign inst_sltu = alu_r && func == FN_SLTU;
    assign inst_and  = alu_r && func == FN_AND;
    assign inst_or   = alu_r && func == FN_OR;
    assign inst_xor  = alu_r && func == FN_XOR;
    assign inst_nor  = alu_r && func == FN_NOR;

    // immediate shifts take rs as zero
    assign inst_sll = special && rs_zero && func == FN_SLL;
    assign inst_srl = special && rs_zero && func == FN_SRL;
    assign inst_sra = special && rs_zero && func == FN_SRA;

    assign is_jr = alu_r && func == FN_JR && ds_inst.r_view.rt == '0
                   && ds_inst.r_view.rd == '0;

    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && rs_zero;
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign is_beq     = (op == OP_BEQ);
    assign is_bne     = (op == OP_BNE);
    assign is_j       = (op == OP_J);
    assign is_jal     = (op == OP_JAL);

    // jal computes pc + 8 through the adder
    assign alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | is_jal;
    assign alu_op[ALU_SUB]  = inst_subu;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll;
    assign alu_op[ALU_SRL]  = inst_srl;
    assign alu_op[ALU_SRA]  = inst_sra;
    assign alu_op[ALU_LUI]  = inst_lui;

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = is_jal;
    assign src2_is_simm = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_zimm = inst_andi | inst_ori | inst_xori;
    assign src2_is_8    = is_jal;
    assign res_from_mem = inst_lw;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                       | inst_xori | inst_lui | inst_lw;

    assign dest = is_jal    ? LINK_REG :
                  dst_is_rt ? ds_inst.r_view.rt :
                              ds_inst.r_view.rd;

    assign imm = ds_inst.i_view.imm16;

    // any writer in the subset; reserved words never write
    assign gr_we  = (|alu_op) & ~inst_sw;
    assign mem_we = inst_sw;

    assign ex_ri = ~(|alu_op | is_beq | is_bne | is_j | is_jr);

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile
    import mips_pkg::*;
(
    input  wire                  clk,
    input  wire [REG_ADDR_W-1:0] raddr1,
    input  wire [REG_ADDR_W-1:0] raddr2,
    input  wire [REG_ADDR_W-1:0] waddr,
    input  wire                  we,
    input  wire [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]      rdata1,
    output logic [XLEN-1:0]      rdata2
);

    logic [XLEN-1:0] regs [0:2**REG_ADDR_W-1];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: operand_bypass.sv
`default_nettype none

module operand_bypass
    import mips_pkg::*;
(
    input  wire [REG_ADDR_W-1:0] rs,
    input  wire [REG_ADDR_W-1:0] rt,
    input  wire [XLEN-1:0]       rf_rdata1,
    input  wire [XLEN-1:0]       rf_rdata2,
    input  wire                  es_valid,
    input  wire                  es_gr_we,
    input  wire                  es_load_op,
    input  wire [REG_ADDR_W-1:0] es_dest,
    input  wire [XLEN-1:0]       es_result,
    input  wire                  ws_valid,
    input  wire                  ws_we,
    input  wire [REG_ADDR_W-1:0] ws_dest,
    input  wire [XLEN-1:0]       ws_wdata,
    output logic [XLEN-1:0]      rs_value,
    output logic [XLEN-1:0]      rt_value,
    output logic                 ready_go
);

    logic load_use;

    // youngest producer wins
    function automatic logic [XLEN-1:0] pick(input logic [REG_ADDR_W-1:0] src,
                                             input logic [XLEN-1:0] rf_value);
        if (src == '0) begin
            return '0;
        end else if (es_valid && es_gr_we && es_dest == src) begin
            return es_result;
        end else if (ws_valid && ws_we && ws_dest == src) begin
            return ws_wdata;
        end
        return rf_value;
    endfunction

    assign rs_value = pick(rs, rf_rdata1);
    assign rt_value = pick(rt, rf_rdata2);

    // load data is not ready until after execute
    assign load_use = es_valid && es_load_op && es_dest != '0
                      && (es_dest == rs || es_dest == rt);
    assign ready_go = !load_use;

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

module branch_unit
    import mips_pkg::*;
(
    input  wire            ds_to_es_valid,
    input  wire            is_beq,
    input  wire            is_bne,
    input  wire            is_j,
    input  wire            is_jal,
    input  wire            is_jr,
    input  wire inst_t     ds_inst,
    input  wire [XLEN-1:0] ds_pc,
    input  wire [XLEN-1:0] rs_value,
    input  wire [XLEN-1:0] rt_value,
    output logic           br_taken,
    output logic [XLEN-1:0] br_target
);

    logic            rs_eq_rt;
    logic [XLEN-1:0] slot_pc;
    logic [XLEN-1:0] br_offset;

    assign rs_eq_rt = (rs_value == rt_value);

    // targets are relative to the delay slot
    assign slot_pc   = ds_pc + 32'd4;
    assign br_offset = {{14{ds_inst.i_view.imm16[15]}}, ds_inst.i_view.imm16, 2'b00};

    assign br_taken = ds_to_es_valid && ((is_beq && rs_eq_rt)
                                         || (is_bne && !rs_eq_rt)
                                         || is_j || is_jal || is_jr);

    assign br_target = (is_beq || is_bne) ? slot_pc + br_offset :
                       is_jr              ? rs_value :
                                            {slot_pc[31:28], ds_inst.j_view.index26, 2'b00};

endmodule

`default_nettype wire

// File: id_stage.sv
`default_nettype none

module id_stage
    import mips_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  flush,
    input  wire                  fs_valid,
    input  wire inst_t           fs_inst,
    input  wire [XLEN-1:0]       fs_pc,
    input  wire                  es_allowin,
    input  wire                  es_valid,
    input  wire                  es_gr_we,
    input  wire                  es_load_op,
    input  wire [REG_ADDR_W-1:0] es_dest,
    input  wire [XLEN-1:0]       es_result,
    input  wire                  ws_valid,
    input  wire                  ws_we,
    input  wire [REG_ADDR_W-1:0] ws_dest,
    input  wire [XLEN-1:0]       ws_wdata,
    output logic                 ds_allowin,
    output logic                 ds_to_es_valid,
    output logic [ALU_OP_W-1:0]  alu_op,
    output logic                 src1_is_sa,
    output logic                 src1_is_pc,
    output logic                 src2_is_simm,
    output logic                 src2_is_zimm,
    output logic                 src2_is_8,
    output logic                 res_from_mem,
    output logic                 gr_we,
    output logic                 mem_we,
    output logic [REG_ADDR_W-1:0] dest,
    output logic [15:0]          imm,
    output logic [XLEN-1:0]      rs_value,
    output logic [XLEN-1:0]      rt_value,
    output logic [XLEN-1:0]      ds_pc,
    output logic                 ds_ex,
    output logic                 br_taken,
    output logic [XLEN-1:0]      br_target
);

    inst_t           ds_inst;
    logic            ready_go;
    logic            is_beq;
    logic            is_bne;
    logic            is_j;
    logic            is_jal;
    logic            is_jr;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;

    // stage valid stays internal, ds_to_es_valid carries it out
    id_stage_reg u_stage_reg (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_valid       (fs_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .es_allowin     (es_allowin),
        .ready_go       (ready_go),
        .ds_valid       (),
        .ds_inst        (ds_inst),
        .ds_pc          (ds_pc),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid)
    );

    inst_decoder u_decoder (
        .ds_inst      (ds_inst),
        .alu_op       (alu_op),
        .src1_is_sa   (src1_is_sa),
        .src1_is_pc   (src1_is_pc),
        .src2_is_simm (src2_is_simm),
        .src2_is_zimm (src2_is_zimm),
        .src2_is_8    (src2_is_8),
        .res_from_mem (res_from_mem),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .dest         (dest),
        .imm          (imm),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_j         (is_j),
        .is_jal       (is_jal),
        .is_jr        (is_jr),
        .ex_ri        (ds_ex)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ds_inst.r_view.rs),
        .raddr2 (ds_inst.r_view.rt),
        .waddr  (ws_dest),
        .we     (ws_valid && ws_we),
        .wdata  (ws_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass u_bypass (
        .rs         (ds_inst.r_view.rs),
        .rt         (ds_inst.r_view.rt),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .es_valid   (es_valid),
        .es_gr_we   (es_gr_we),
        .es_load_op (es_load_op),
        .es_dest    (es_dest),
        .es_result  (es_result),
        .ws_valid   (ws_valid),
        .ws_we      (ws_we),
        .ws_dest    (ws_dest),
        .ws_wdata   (ws_wdata),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .ready_go   (ready_go)
    );

    branch_unit u_branch (
        .ds_to_es_valid (ds_to_es_valid),
        .is_beq         (is_beq),
        .is_bne         (is_bne),
        .is_j           (is_j),
        .is_jal         (is_jal),
        .is_jr          (is_jr),
        .ds_inst        (ds_inst),
        .ds_pc          (ds_pc),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .br_taken       (br_taken),
        .br_target      (br_target)
    );

endmodule

`default_nettype wire

// File: tb_id_stage.sv
`default_nettype none

module tb_id_stage
    import mips_pkg::*;
();

    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = 5 + 32 + N_RANDOM * 6 + 60;
    localparam int TIMEOUT    = MAX_CYCLES * 20 + 500;

    localparam logic [5:0] FN_LIST [12] = '{FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_ADDU, FN_SUBU,
                                            FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [5:0] OP_LIST [13] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU, OP_SLTI,
                                            OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                            OP_LW, OP_SW};

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_simm;
        logic                  src2_is_zimm;
        logic                  src2_is_8;
        logic                  res_from_mem;
        logic                  gr_we;
        logic                  mem_we;
        logic                  ex;
        logic [REG_ADDR_W-1:0] dest;
        logic [15:0]           imm;
        logic [XLEN-1:0]       rs_value;
        logic [XLEN-1:0]       rt_value;
        logic                  is_br;
        logic                  taken;
        logic [XLEN-1:0]       target;
    } decode_exp_t;

    logic                  clk, reset, flush;
    logic                  fs_valid;
    inst_t                 fs_inst;
    logic [XLEN-1:0]       fs_pc;
    logic                  es_allowin, es_valid, es_gr_we, es_load_op;
    logic [REG_ADDR_W-1:0] es_dest;
    logic [XLEN-1:0]       es_result;
    logic                  ws_valid, ws_we;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic [XLEN-1:0]       ws_wdata;
    logic                  ds_allowin, ds_to_es_valid;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  src1_is_sa, src1_is_pc, src2_is_simm, src2_is_zimm, src2_is_8;
    logic                  res_from_mem, gr_we, mem_we, ds_ex, br_taken;
    logic [REG_ADDR_W-1:0] dest;
    logic [15:0]           imm;
    logic [XLEN-1:0]       rs_value, rt_value, ds_pc, br_target;

    // testbench copy of the stage and the register file
    logic            random_bypass;
    logic [XLEN-1:0] rf_model [32];
    logic            model_valid;
    inst_t           model_inst;
    logic [XLEN-1:0] model_pc;
    logic            exp_ready;
    logic            exp_allowin;
    logic [XLEN-1:0] held_pc;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [XLEN-1:0] operand_value(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return '0;
        end else if (es_valid && es_gr_we && es_dest == src) begin
            return es_result;
        end else if (ws_valid && ws_we && ws_dest == src) begin
            return ws_wdata;
        end
        return rf_model[src];
    endfunction

    function automatic decode_exp_t expected_decode(input inst_t w, input logic [XLEN-1:0] pc);
        decode_exp_t     e;
        int              alu_bit;
        logic [5:0]      op;
        logic            dst_rt, beq, bne, jmp, jal, jr, eq;
        logic [XLEN-1:0] slot;
        e = '0;
        alu_bit = -1;
        {dst_rt, beq, bne, jmp, jr} = '0;
        op = w.r_view.op;
        case (op)
            OP_SPECIAL: begin
                case (w.r_view.func)
                    FN_ADDU: alu_bit = ALU_ADD;
                    FN_SUBU: alu_bit = ALU_SUB;
                    FN_SLT:  alu_bit = ALU_SLT;
                    FN_SLTU: alu_bit = ALU_SLTU;
                    FN_AND:  alu_bit = ALU_AND;
                    FN_OR:   alu_bit = ALU_OR;
                    FN_XOR:  alu_bit = ALU_XOR;
                    FN_NOR:  alu_bit = ALU_NOR;
                    FN_SLL:  alu_bit = ALU_SLL;
                    FN_SRL:  alu_bit = ALU_SRL;
                    FN_SRA:  alu_bit = ALU_SRA;
                    FN_JR:   jr = w.r_view.sa == '0 && w.r_view.rt == '0 && w.r_view.rd == '0;
                    default: alu_bit = -1;
                endcase
                // shifts want rs zero, the others want sa zero
                e.src1_is_sa = alu_bit >= ALU_SLL;
                if (e.src1_is_sa ? w.r_view.rs != '0 : w.r_view.sa != '0) begin
                    alu_bit = -1;
                    e.src1_is_sa = 1'b0;
                end
            end
            OP_ADDIU: alu_bit = ALU_ADD;
            OP_SLTI:  alu_bit = ALU_SLT;
            OP_SLTIU: alu_bit = ALU_SLTU;
            OP_ANDI:  alu_bit = ALU_AND;
            OP_ORI:   alu_bit = ALU_OR;
            OP_XORI:  alu_bit = ALU_XOR;
            OP_LUI:   alu_bit = (w.i_view.rs == '0) ? ALU_LUI : -1;
            OP_LW:    alu_bit = ALU_ADD;
            OP_SW:    alu_bit = ALU_ADD;
            OP_JAL:   alu_bit = ALU_ADD;
            OP_BEQ:   beq = 1'b1;
            OP_BNE:   bne = 1'b1;
            OP_J:     jmp = 1'b1;
            default:  alu_bit = -1;
        endcase
        jal = (op == OP_JAL);
        e.src2_is_zimm = op inside {OP_ANDI, OP_ORI, OP_XORI};
        e.src2_is_simm = op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW, OP_SW}
                         || alu_bit == ALU_LUI;
        dst_rt = e.src2_is_zimm || (e.src2_is_simm && op != OP_SW);
        e.src1_is_pc = jal;
        e.src2_is_8 = jal;
        e.res_from_mem = (op == OP_LW);
        e.mem_we = (op == OP_SW);
        if (alu_bit >= 0) begin
            e.alu_op = ALU_OP_W'(1) << alu_bit;
        end
        e.gr_we = alu_bit >= 0 && !e.mem_we;
        e.ex = alu_bit < 0 && !(beq || bne || jmp || jr);
        e.dest = jal ? LINK_REG : dst_rt ? w.r_view.rt : w.r_view.rd;
        e.imm = w.i_view.imm16;
        e.rs_value = operand_value(w.r_view.rs);
        e.rt_value = operand_value(w.r_view.rt);
        eq = (e.rs_value == e.rt_value);
        e.is_br = beq || bne || jmp || jal || jr;
        e.taken = (beq && eq) || (bne && !eq) || jmp || jal || jr;
        slot = pc + 32'd4;
        if (beq || bne) begin
            e.target = slot + {{14{w.i_view.imm16[15]}}, w.i_view.imm16, 2'b00};
        end else if (jr) begin
            e.target = e.rs_value;
        end else begin
            e.target = {slot[31:28], w.j_view.index26, 2'b00};
        end
        return e;
    endfunction

    function automatic inst_t random_inst();
        logic [5:0] fn;
        logic [5:0] op;
        logic [4:0] rs, rt, rd, sa;
        inst_t      w;
        fn = FN_LIST[4'($urandom % 12)];
        op = OP_LIST[4'($urandom % 13)];
        rs = 5'($urandom);
        rt = 5'($urandom);
        rd = 5'($urandom);
        sa = 5'd0;
        w = $urandom;
        case ($urandom % 4)
            0, 1: begin
                if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                    sa = 5'($urandom);
                    rs = '0;
                end
                if (fn == FN_JR) begin
                    rt = '0;
                    rd = '0;
                end
                w = {OP_SPECIAL, rs, rt, rd, sa, fn};
            end
            2: begin
                if (op == OP_LUI) begin
                    rs = '0;
                end
                // give beq/bne equal operands now and then
                if (op inside {OP_BEQ, OP_BNE} && $urandom % 2 == 0) begin
                    rt = rs;
                end
                w = {op, rs, rt, 16'($urandom)};
            end
            default: w = $urandom;
        endcase
        return w;
    endfunction

    // offer one instruction until decode takes it
    task automatic send_inst(input inst_t w, input logic [XLEN-1:0] pc);
        logic accepted;
        accepted = 1'b0;
        fs_valid = 1'b1;
        fs_inst = w;
        fs_pc = pc;
        while (!accepted) begin
            @(negedge clk);
            accepted = ds_allowin;
            @(posedge clk);
            #2;
        end
        fs_valid = 1'b0;
    endtask

    assign exp_ready = !(es_valid && es_load_op && es_dest != '0
                         && (es_dest == model_inst.r_view.rs || es_dest == model_inst.r_view.rt));
    assign exp_allowin = !model_valid || (exp_ready && es_allowin);

    always @(posedge clk) begin
        if (ws_valid && ws_we && ws_dest != '0) begin
            rf_model[ws_dest] <= ws_wdata;
        end
        if (fs_valid && exp_allowin) begin
            model_inst <= fs_inst;
            model_pc <= fs_pc;
        end
        if (reset || flush) begin
            model_valid <= 1'b0;
        end else if (exp_allowin) begin
            model_valid <= fs_valid;
        end
    end

    always @(posedge clk) begin
        if (random_bypass) begin
            #2;
            es_allowin = ($urandom % 4) != 0;
            es_valid = 1'($urandom);
            es_gr_we = 1'($urandom);
            es_load_op = ($urandom % 8) == 0;
            es_dest = 5'($urandom);
            es_result = $urandom;
            ws_valid = 1'($urandom);
            ws_we = 1'($urandom);
            ws_dest = 5'($urandom);
            ws_wdata = $urandom;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        decode_exp_t e;
        if (!reset) begin
            e = expected_decode(model_inst, model_pc);
            check_value("ds_allowin", 32'(ds_allowin), 32'(exp_allowin));
            check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'(model_valid && exp_ready));
            check_value("br_taken", 32'(br_taken), 32'(model_valid && exp_ready && e.taken));
            if (model_valid && exp_ready) begin
                check_value("alu_op", 32'(alu_op), 32'(e.alu_op));
                check_value("src1_is_sa", 32'(src1_is_sa), 32'(e.src1_is_sa));
                check_value("src1_is_pc", 32'(src1_is_pc), 32'(e.src1_is_pc));
                check_value("src2_is_simm", 32'(src2_is_simm), 32'(e.src2_is_simm));
                check_value("src2_is_zimm", 32'(src2_is_zimm), 32'(e.src2_is_zimm));
                check_value("src2_is_8", 32'(src2_is_8), 32'(e.src2_is_8));
                check_value("res_from_mem", 32'(res_from_mem), 32'(e.res_from_mem));
                check_value("gr_we", 32'(gr_we), 32'(e.gr_we));
                check_value("mem_we", 32'(mem_we), 32'(e.mem_we));
                check_value("ds_ex", 32'(ds_ex), 32'(e.ex));
                check_value("imm", 32'(imm), 32'(e.imm));
                check_value("rs_value", rs_value, e.rs_value);
                check_value("rt_value", rt_value, e.rt_value);
                check_value("ds_pc", ds_pc, model_pc);
                if (e.gr_we) begin
                    check_value("dest", 32'(dest), 32'(e.dest));
                end
                if (e.is_br) begin
                    check_value("br_target", br_target, e.target);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h1373f205));
        reset = 1'b1;
        flush = 1'b0;
        fs_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        {es_allowin, es_valid, es_gr_we, es_load_op} = 4'b1000;
        es_dest = '0;
        es_result = '0;
        {ws_valid, ws_we} = 2'b00;
        ws_dest = '0;
        ws_wdata = '0;
        random_bypass = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // fill every register through write-back
        {ws_valid, ws_we} = 2'b11;
        for (int r = 0; r < 32; r++) begin
            ws_dest = 5'(r);
            ws_wdata = $urandom;
            @(posedge clk);
            #2;
        end
        ws_valid = 1'b0;

        random_bypass = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            send_inst(random_inst(), {30'($urandom), 2'b00});
        end
        random_bypass = 1'b0;
        @(posedge clk);
        #2;

        // drain the stage before the directed tests
        es_allowin = 1'b1;
        {es_valid, es_load_op} = 2'b00;
        ws_valid = 1'b0;
        @(posedge clk);
        #2;

        // forwarding priority while es_allowin holds the instruction
        es_allowin = 1'b0;
        {es_valid, es_gr_we, es_load_op} = 3'b110;
        es_dest = 5'd9;
        es_result = 32'h1111_0009;
        {ws_valid, ws_we} = 2'b11;
        ws_dest = 5'd9;
        ws_wdata = 32'h2222_0009;
        send_inst({OP_SPECIAL, 5'd9, 5'd0, 5'd3, 5'd0, FN_ADDU}, 32'h0040_0100);
        @(negedge clk);
        check_value("rs_value", rs_value, 32'h1111_0009);
        @(posedge clk);
        #2;
        es_dest = 5'd0;
        ws_wdata = 32'h4444_0009;
        @(negedge clk);
        check_value("rs_value", rs_value, 32'h4444_0009);
        check_value("rt_value", rt_value, 32'h0);
        @(posedge clk);
        #2;
        {es_valid, ws_valid} = 2'b00;
        @(negedge clk);
        check_value("rs_value", rs_value, 32'h4444_0009);
        @(posedge clk);
        #2;
        es_allowin = 1'b1;
        @(posedge clk);
        #2;

        // load-use on rt
        {es_valid, es_gr_we, es_load_op} = 3'b111;
        es_dest = 5'd7;
        es_result = 32'h3333_0007;
        send_inst({OP_SPECIAL, 5'd4, 5'd7, 5'd8, 5'd0, FN_SUBU}, 32'h0040_0200);
        repeat (3) begin
            @(negedge clk);
            check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'h0);
            check_value("ds_allowin", 32'(ds_allowin), 32'h0);
        end
        @(posedge clk);
        #2;
        es_load_op = 1'b0;
        @(negedge clk);
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'h1);
        check_value("rt_value", rt_value, 32'h3333_0007);
        @(posedge clk);
        #2;
        es_valid = 1'b0;

        // back-pressure holds the stage, then flush empties it
        es_allowin = 1'b0;
        send_inst({OP_ORI, 5'd2, 5'd5, 16'h8001}, 32'h0040_0300);
        held_pc = ds_pc;
        fs_valid = 1'b1;
        fs_inst = random_inst();
        fs_pc = 32'h0040_0400;
        repeat (3) begin
            @(negedge clk);
            check_value("ds_allowin", 32'(ds_allowin), 32'h0);
            check_value("ds_pc", ds_pc, held_pc);
        end
        @(posedge clk);
        #2;
        fs_valid = 1'b0;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        es_allowin = 1'b1;
        @(negedge clk);
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'h0);
        repeat (2) @(posedge clk);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
mips_pkg.sv
id_stage_reg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_id_stage
RTL_TOP    := id_stage
FILELIST   := build.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
